//--- design/exec_pkg.sv
package exec_pkg;

    parameter int DATA_W     = 32;
    parameter int REG_ADDR_W = 5;
    parameter int FL_W       = 2;    // bit 0 zero, bit 1 negative

    // one 5-bit op word, seen by the ALU and by the branch unit
    typedef union packed {
        struct packed {
            logic       inv;         // forces FN_ERR
            logic [3:0] fn;
        } alu;
        struct packed {
            logic [2:0] rsvd;
            logic [1:0] cond;
        } br;
    } op_word_t;

    // ALU functions
    localparam logic [3:0] FN_ADD    = 4'b0000;
    localparam logic [3:0] FN_SUB    = 4'b0001;
    localparam logic [3:0] FN_AND    = 4'b0010;
    localparam logic [3:0] FN_OR     = 4'b0011;
    localparam logic [3:0] FN_XOR    = 4'b0100;
    localparam logic [3:0] FN_SHL    = 4'b0101;
    localparam logic [3:0] FN_SHR    = 4'b0110;
    localparam logic [3:0] FN_SRA    = 4'b0111;
    localparam logic [3:0] FN_PASS_B = 4'b1000;
    localparam logic [3:0] FN_STORE  = 4'b1110;  // add, store data from operand 1
    localparam logic [3:0] FN_ERR    = 4'b1111;

    // branch conditions
    localparam logic [1:0] COND_EQ = 2'b00;
    localparam logic [1:0] COND_NE = 2'b01;
    localparam logic [1:0] COND_LT = 2'b10;
    localparam logic [1:0] COND_AL = 2'b11;

    // operand forwarding selects
    localparam logic [1:0] FWD_REG = 2'b00;
    localparam logic [1:0] FWD_EXM = 2'b01;
    localparam logic [1:0] FWD_WB  = 2'b10;
    localparam logic [1:0] FWD_LR  = 2'b11;

    // flag and link selects
    localparam logic [1:0] FLS_ID  = 2'b00;
    localparam logic [1:0] FLS_EXM = 2'b01;
    localparam logic [1:0] FLS_WB  = 2'b10;

endpackage

//--- design/forward_unit.sv
`timescale 1ns/100ps

module forward_unit (
    input  logic [exec_pkg::REG_ADDR_W-1:0] src1,
    input  logic [exec_pkg::REG_ADDR_W-1:0] src2,
    input  logic                            src1_is_lr,
    input  logic                            issue_valid,
    input  logic                            exm_valid,
    input  logic [exec_pkg::REG_ADDR_W-1:0] exm_dest,
    input  logic                            exm_reg_wrt_en,
    input  logic                            exm_fl_wrt,
    input  logic                            exm_lr_wrt,
    input  logic                            wb_valid,
    input  logic [exec_pkg::REG_ADDR_W-1:0] wb_dest,
    input  logic                            wb_reg_wrt_en,
    input  logic                            wb_fl_wrt,
    input  logic                            wb_lr_wrt,
    output logic [1:0]                      fwd1_sel,
    output logic [1:0]                      fwd2_sel,
    output logic [1:0]                      fwd_fl_sel,
    output logic [1:0]                      fwd_lr_sel
);

    logic exm_reg_live;  // EX/MEM holds a register writer
    logic wb_reg_live;

    assign exm_reg_live = issue_valid && exm_valid && exm_reg_wrt_en;
    assign wb_reg_live  = issue_valid && wb_valid && wb_reg_wrt_en;

    // operand select for one source, EX/MEM beats MEM/WB
    function automatic logic [1:0] reg_sel(
        input logic [exec_pkg::REG_ADDR_W-1:0] src,
        input logic [exec_pkg::REG_ADDR_W-1:0] exm_d,
        input logic [exec_pkg::REG_ADDR_W-1:0] wb_d,
        input logic                            exm_live,
        input logic                            wb_live
    );
        if (src == '0) begin
            reg_sel = exec_pkg::FWD_REG;  // r0 never forwarded
        end else if (exm_live && (exm_d == src)) begin
            reg_sel = exec_pkg::FWD_EXM;
        end else if (wb_live && (wb_d == src)) begin
            reg_sel = exec_pkg::FWD_WB;
        end else begin
            reg_sel = exec_pkg::FWD_REG;
        end
    endfunction

    // youngest valid writer of flags or link
    function automatic logic [1:0] side_sel(input logic exm_live, input logic wb_live);
        if (exm_live) begin
            side_sel = exec_pkg::FLS_EXM;
        end else if (wb_live) begin
            side_sel = exec_pkg::FLS_WB;
        end else begin
            side_sel = exec_pkg::FLS_ID;
        end
    endfunction

    assign fwd1_sel   = src1_is_lr ? exec_pkg::FWD_LR
                                   : reg_sel(src1, exm_dest, wb_dest, exm_reg_live, wb_reg_live);
    assign fwd2_sel   = reg_sel(src2, exm_dest, wb_dest, exm_reg_live, wb_reg_live);
    assign fwd_fl_sel = side_sel(issue_valid && exm_valid && exm_fl_wrt,
                                 issue_valid && wb_valid && wb_fl_wrt);
    assign fwd_lr_sel = side_sel(issue_valid && exm_valid && exm_lr_wrt,
                                 issue_valid && wb_valid && wb_lr_wrt);

endmodule

//--- design/alu.sv
`timescale 1ns/100ps

module alu #(
    parameter int DATA_W = exec_pkg::DATA_W
) (
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  logic [3:0]        fn,
    output logic [DATA_W-1:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // shifts use low 5 bits only

    always_comb begin
        case (fn)
            exec_pkg::FN_ADD: begin
                result = a + b;
            end
            exec_pkg::FN_SUB: begin
                result = a - b;
            end
            exec_pkg::FN_AND: begin
                result = a & b;
            end
            exec_pkg::FN_OR: begin
                result = a | b;
            end
            exec_pkg::FN_XOR: begin
                result = a ^ b;
            end
            exec_pkg::FN_SHL: begin
                result = a << shamt;
            end
            exec_pkg::FN_SHR: begin
                result = a >> shamt;
            end
            exec_pkg::FN_SRA: begin
                result = $signed(a) >>> shamt;  // sign fill
            end
            exec_pkg::FN_PASS_B: begin
                result = b;
            end
            exec_pkg::FN_STORE: begin
                result = a + b;     // address calc
            end
            exec_pkg::FN_ERR: begin
                result = '0;
            end
            default: begin
                result = '0;        // unused codes
            end
        endcase
    end

endmodule

//--- design/branch_unit.sv
`timescale 1ns/100ps

module branch_unit #(
    parameter int DATA_W = exec_pkg::DATA_W
) (
    input  logic                      branch,
    input  logic                      jump,
    input  logic [1:0]                cond,
    input  logic [exec_pkg::FL_W-1:0] fl,
    input  logic [DATA_W-1:0]         pc,
    input  logic [DATA_W-1:0]         imm,
    input  logic [DATA_W-1:0]         reg_a,
    output logic [DATA_W-1:0]         pc_next,
    output logic                      taken,
    output logic [DATA_W-1:0]         lr_wrt_data
);

    logic [DATA_W-1:0] pc_4;
    logic [DATA_W-1:0] pc_imm;
    logic              cond_met;

    assign pc_4   = pc + DATA_W'(4);
    assign pc_imm = pc + imm + DATA_W'(4);  // relative to the next instruction

    always_comb begin
        case (cond)
            exec_pkg::COND_EQ: cond_met = fl[0];
            exec_pkg::COND_NE: cond_met = !fl[0];
            exec_pkg::COND_LT: cond_met = fl[1];
            default:           cond_met = 1'b1;  // COND_AL
        endcase
    end

    always_comb begin
        if (jump) begin
            pc_next = reg_a;    // register indirect
            taken   = 1'b1;
        end else if (branch && cond_met) begin
            pc_next = pc_imm;
            taken   = 1'b1;
        end else begin
            pc_next = pc_4;
            taken   = 1'b0;
        end
    end

    // return address, only written back when lr_wrt is set
    assign lr_wrt_data = pc_4;

endmodule

//--- design/execute.sv
`timescale 1ns/100ps

module execute #(
    parameter int DATA_W = exec_pkg::DATA_W
) (
    input  exec_pkg::op_word_t        op,
    input  logic                      branch,
    input  logic                      jump,
    input  logic                      alu_src,
    input  logic [DATA_W-1:0]         pc,
    input  logic [DATA_W-1:0]         imm,
    input  logic [DATA_W-1:0]         reg_1,
    input  logic [DATA_W-1:0]         reg_2,
    input  logic [DATA_W-1:0]         id_lr,
    input  logic [exec_pkg::FL_W-1:0] id_fl,
    input  logic [1:0]                fwd1_sel,
    input  logic [1:0]                fwd2_sel,
    input  logic [1:0]                fwd_fl_sel,
    input  logic [1:0]                fwd_lr_sel,
    input  logic [DATA_W-1:0]         exm_alu_out,
    input  logic [DATA_W-1:0]         exm_lr,
    input  logic [exec_pkg::FL_W-1:0] exm_fl,
    input  logic [DATA_W-1:0]         wb_data,
    input  logic [DATA_W-1:0]         wb_lr,
    input  logic [exec_pkg::FL_W-1:0] wb_fl,
    output logic [DATA_W-1:0]         alu_out,
    output logic [exec_pkg::FL_W-1:0] flags,
    output logic [DATA_W-1:0]         store_data,
    output logic [DATA_W-1:0]         pc_next,
    output logic                      taken,
    output logic [DATA_W-1:0]         lr_wrt_data
);

    logic [3:0]                fn;
    logic [DATA_W-1:0]         fwd_lr;
    logic [exec_pkg::FL_W-1:0] fwd_fl;
    logic [DATA_W-1:0]         opnd1;
    logic [DATA_W-1:0]         opnd2;
    logic [DATA_W-1:0]         alu_b;

    assign fn = op.alu.inv ? exec_pkg::FN_ERR : op.alu.fn;

    always_comb begin
        case (fwd_lr_sel)
            exec_pkg::FLS_EXM: fwd_lr = exm_lr;
            exec_pkg::FLS_WB:  fwd_lr = wb_lr;
            default:           fwd_lr = id_lr;
        endcase
        case (fwd_fl_sel)
            exec_pkg::FLS_EXM: fwd_fl = exm_fl;
            exec_pkg::FLS_WB:  fwd_fl = wb_fl;
            default:           fwd_fl = id_fl;
        endcase
        case (fwd1_sel)
            exec_pkg::FWD_EXM: opnd1 = exm_alu_out;
            exec_pkg::FWD_WB:  opnd1 = wb_data;
            exec_pkg::FWD_LR:  opnd1 = fwd_lr;
            default:           opnd1 = reg_1;
        endcase
        case (fwd2_sel)
            exec_pkg::FWD_EXM: opnd2 = exm_alu_out;
            exec_pkg::FWD_WB:  opnd2 = wb_data;
            default:           opnd2 = reg_2;  // no link on operand 2
        endcase
    end

    assign alu_b = alu_src ? imm : opnd2;

    alu #(.DATA_W(DATA_W)) u_alu (
        .a      (opnd1),
        .b      (alu_b),
        .fn     (fn),
        .result (alu_out)
    );

    assign flags[0]   = ~|alu_out;          // zero
    assign flags[1]   = alu_out[DATA_W-1];  // negative
    assign store_data = (fn == exec_pkg::FN_STORE) ? opnd1 : opnd2;

    branch_unit #(.DATA_W(DATA_W)) u_branch_unit (
        .branch      (branch),
        .jump        (jump),
        .cond        (op.br.cond),
        .fl          (fwd_fl),
        .pc          (pc),
        .imm         (imm),
        .reg_a       (opnd1),
        .pc_next     (pc_next),
        .taken       (taken),
        .lr_wrt_data (lr_wrt_data)
    );

endmodule

//--- design/pipe_regs.sv
`timescale 1ns/100ps

module pipe_regs #(
    parameter int DATA_W = exec_pkg::DATA_W
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            issue_valid,
    input  logic [exec_pkg::REG_ADDR_W-1:0] dest,
    input  logic                            reg_wrt_en,
    input  logic                            fl_wrt,
    input  logic                            lr_wrt,
    input  logic                            mem_wrt,
    input  logic [DATA_W-1:0]               alu_out,
    input  logic [exec_pkg::FL_W-1:0]       flags,
    input  logic [DATA_W-1:0]               store_data,
    input  logic [DATA_W-1:0]               pc_next,
    input  logic                            taken,
    input  logic [DATA_W-1:0]               lr_wrt_data,
    output logic                            exm_valid,
    output logic [exec_pkg::REG_ADDR_W-1:0] exm_dest,
    output logic                            exm_reg_wrt_en,
    output logic [exec_pkg::FL_W-1:0]       exm_fl,
    output logic                            exm_fl_wrt,
    output logic [DATA_W-1:0]               exm_lr,
    output logic                            exm_lr_wrt,
    output logic [DATA_W-1:0]               exm_alu_out,
    output logic [DATA_W-1:0]               exm_pc_next,
    output logic                            exm_taken,
    output logic [DATA_W-1:0]               exm_store_data,
    output logic                            exm_mem_wrt,
    output logic                            wb_valid,
    output logic [exec_pkg::REG_ADDR_W-1:0] wb_dest,
    output logic [DATA_W-1:0]               wb_data,
    output logic                            wb_reg_wrt_en,
    output logic [exec_pkg::FL_W-1:0]       wb_fl,
    output logic                            wb_fl_wrt,
    output logic [DATA_W-1:0]               wb_lr,
    output logic                            wb_lr_wrt
);

    // control, a bubble clears valid and every enable
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exm_valid      <= 1'b0;
            exm_reg_wrt_en <= 1'b0;
            exm_fl_wrt     <= 1'b0;
            exm_lr_wrt     <= 1'b0;
            exm_mem_wrt    <= 1'b0;
            exm_taken      <= 1'b0;
            wb_valid       <= 1'b0;
            wb_reg_wrt_en  <= 1'b0;
            wb_fl_wrt      <= 1'b0;
            wb_lr_wrt      <= 1'b0;
        end else begin
            exm_valid      <= issue_valid;
            exm_reg_wrt_en <= issue_valid & reg_wrt_en;
            exm_fl_wrt     <= issue_valid & fl_wrt;
            exm_lr_wrt     <= issue_valid & lr_wrt;
            exm_mem_wrt    <= issue_valid & mem_wrt;
            exm_taken      <= issue_valid & taken;
            wb_valid       <= exm_valid;
            wb_reg_wrt_en  <= exm_reg_wrt_en;
            wb_fl_wrt      <= exm_fl_wrt;
            wb_lr_wrt      <= exm_lr_wrt;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        exm_dest       <= dest;
        exm_fl         <= flags;
        exm_lr         <= lr_wrt_data;
        exm_alu_out    <= alu_out;
        exm_pc_next    <= pc_next;
        exm_store_data <= store_data;
        wb_dest        <= exm_dest;
        wb_data        <= exm_alu_out;  // no memory, result passes through
        wb_fl          <= exm_fl;
        wb_lr          <= exm_lr;
    end

endmodule

//--- design/exec_top.sv
`timescale 1ns/100ps

module exec_top #(
    parameter int DATA_W = exec_pkg::DATA_W
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            issue_valid,
    input  logic                            branch,
    input  logic                            jump,
    input  logic                            alu_src,
    input  logic                            reg_wrt_en,
    input  logic                            fl_wrt,
    input  logic                            lr_wrt,
    input  logic                            mem_wrt,
    input  logic                            src1_is_lr,
    input  exec_pkg::op_word_t              op,
    input  logic [DATA_W-1:0]               imm,
    input  logic [DATA_W-1:0]               pc,
    input  logic [DATA_W-1:0]               reg_1,
    input  logic [DATA_W-1:0]               reg_2,
    input  logic [exec_pkg::REG_ADDR_W-1:0] src1,
    input  logic [exec_pkg::REG_ADDR_W-1:0] src2,
    input  logic [exec_pkg::REG_ADDR_W-1:0] dest,
    input  logic [DATA_W-1:0]               id_lr,
    input  logic [exec_pkg::FL_W-1:0]       id_fl,
    output logic [DATA_W-1:0]               exm_alu_out,
    output logic [DATA_W-1:0]               exm_pc_next,
    output logic                            exm_taken,
    output logic [DATA_W-1:0]               exm_store_data,
    output logic                            exm_mem_wrt,
    output logic                            wb_valid,
    output logic [exec_pkg::REG_ADDR_W-1:0] wb_dest,
    output logic [DATA_W-1:0]               wb_data,
    output logic                            wb_reg_wrt_en,
    output logic [exec_pkg::FL_W-1:0]       wb_fl,
    output logic                            wb_fl_wrt,
    output logic [DATA_W-1:0]               wb_lr,
    output logic                            wb_lr_wrt
);

    logic [1:0]                      fwd1_sel;
    logic [1:0]                      fwd2_sel;
    logic [1:0]                      fwd_fl_sel;
    logic [1:0]                      fwd_lr_sel;
    logic [DATA_W-1:0]               alu_out;
    logic [exec_pkg::FL_W-1:0]       flags;
    logic [DATA_W-1:0]               store_data;
    logic [DATA_W-1:0]               pc_next;
    logic                            taken;
    logic [DATA_W-1:0]               lr_wrt_data;
    logic                            exm_valid;
    logic [exec_pkg::REG_ADDR_W-1:0] exm_dest;
    logic                            exm_reg_wrt_en;
    logic [exec_pkg::FL_W-1:0]       exm_fl;
    logic                            exm_fl_wrt;
    logic [DATA_W-1:0]               exm_lr;
    logic                            exm_lr_wrt;

    forward_unit u_forward_unit (
        .src1           (src1),
        .src2           (src2),
        .src1_is_lr     (src1_is_lr),
        .issue_valid    (issue_valid),
        .exm_valid      (exm_valid),
        .exm_dest       (exm_dest),
        .exm_reg_wrt_en (exm_reg_wrt_en),
        .exm_fl_wrt     (exm_fl_wrt),
        .exm_lr_wrt     (exm_lr_wrt),
        .wb_valid       (wb_valid),
        .wb_dest        (wb_dest),
        .wb_reg_wrt_en  (wb_reg_wrt_en),
        .wb_fl_wrt      (wb_fl_wrt),
        .wb_lr_wrt      (wb_lr_wrt),
        .fwd1_sel       (fwd1_sel),
        .fwd2_sel       (fwd2_sel),
        .fwd_fl_sel     (fwd_fl_sel),
        .fwd_lr_sel     (fwd_lr_sel)
    );

    execute #(.DATA_W(DATA_W)) u_execute (
        .op          (op),
        .branch      (branch),
        .jump        (jump),
        .alu_src     (alu_src),
        .pc          (pc),
        .imm         (imm),
        .reg_1       (reg_1),
        .reg_2       (reg_2),
        .id_lr       (id_lr),
        .id_fl       (id_fl),
        .fwd1_sel    (fwd1_sel),
        .fwd2_sel    (fwd2_sel),
        .fwd_fl_sel  (fwd_fl_sel),
        .fwd_lr_sel  (fwd_lr_sel),
        .exm_alu_out (exm_alu_out),
        .exm_lr      (exm_lr),
        .exm_fl      (exm_fl),
        .wb_data     (wb_data),
        .wb_lr       (wb_lr),
        .wb_fl       (wb_fl),
        .alu_out     (alu_out),
        .flags       (flags),
        .store_data  (store_data),
        .pc_next     (pc_next),
        .taken       (taken),
        .lr_wrt_data (lr_wrt_data)
    );

    pipe_regs #(.DATA_W(DATA_W)) u_pipe_regs (
        .clk            (clk),
        .arst_n         (arst_n),
        .issue_valid    (issue_valid),
        .dest           (dest),
        .reg_wrt_en     (reg_wrt_en),
        .fl_wrt         (fl_wrt),
        .lr_wrt         (lr_wrt),
        .mem_wrt        (mem_wrt),
        .alu_out        (alu_out),
        .flags          (flags),
        .store_data     (store_data),
        .pc_next        (pc_next),
        .taken          (taken),
        .lr_wrt_data    (lr_wrt_data),
        .exm_valid      (exm_valid),
        .exm_dest       (exm_dest),
        .exm_reg_wrt_en (exm_reg_wrt_en),
        .exm_fl         (exm_fl),
        .exm_fl_wrt     (exm_fl_wrt),
        .exm_lr         (exm_lr),
        .exm_lr_wrt     (exm_lr_wrt),
        .exm_alu_out    (exm_alu_out),
        .exm_pc_next    (exm_pc_next),
        .exm_taken      (exm_taken),
        .exm_store_data (exm_store_data),
        .exm_mem_wrt    (exm_mem_wrt),
        .wb_valid       (wb_valid),
        .wb_dest        (wb_dest),
        .wb_data        (wb_data),
        .wb_reg_wrt_en  (wb_reg_wrt_en),
        .wb_fl          (wb_fl),
        .wb_fl_wrt      (wb_fl_wrt),
        .wb_lr          (wb_lr),
        .wb_lr_wrt      (wb_lr_wrt)
    );

endmodule

//--- bench/exec_tb.sv
`timescale 1ns/100ps

module exec_tb;

    localparam int DW = exec_pkg::DATA_W;
    localparam int RW = exec_pkg::REG_ADDR_W;

    // control bits of the send task
    localparam logic [7:0] C_BR  = 8'h01;
    localparam logic [7:0] C_JMP = 8'h02;
    localparam logic [7:0] C_IMM = 8'h04;
    localparam logic [7:0] C_RW  = 8'h08;
    localparam logic [7:0] C_FW  = 8'h10;
    localparam logic [7:0] C_LW  = 8'h20;
    localparam logic [7:0] C_MW  = 8'h40;
    localparam logic [7:0] C_LR  = 8'h80;

    // reset, alu, forwarding, branches, jump, stores
    localparam int TEST_CYCLES   = 5 + 47 + 13 + 38 + 7 + 7;
    localparam int MARGIN_CYCLES = 20;

    logic clk;
    logic arst_n;
    logic issue_valid;
    logic branch, jump, alu_src, reg_wrt_en, fl_wrt, lr_wrt, mem_wrt, src1_is_lr;
    exec_pkg::op_word_t op;
    logic [DW-1:0] imm, pc, reg_1, reg_2, id_lr;
    logic [RW-1:0] src1, src2, dest;
    logic [1:0]    id_fl;
    logic [DW-1:0] exm_alu_out, exm_pc_next, exm_store_data;
    logic          exm_taken, exm_mem_wrt;
    logic          wb_valid, wb_reg_wrt_en, wb_fl_wrt, wb_lr_wrt;
    logic [RW-1:0] wb_dest;
    logic [DW-1:0] wb_data, wb_lr;
    logic [1:0]    wb_fl;

    // model state, newest values and retired values
    logic [DW-1:0] model_rf [32];
    logic [DW-1:0] arch_rf  [32];
    logic [1:0]    model_fl, arch_fl;
    logic [DW-1:0] model_lr, arch_lr;
    logic [DW-1:0] next_pc;

    // expected contents, index 0 is EX/MEM, 1 is MEM/WB, 2 just left MEM/WB
    logic          p_valid [3];
    logic [RW-1:0] p_dest  [3];
    logic          p_rw    [3];
    logic          p_fw    [3];
    logic          p_lw    [3];
    logic [DW-1:0] p_data  [3];
    logic [1:0]    p_fl    [3];
    logic [DW-1:0] p_lr    [3];

    // seen at EX/MEM only
    logic          p_mw;
    logic          p_taken;
    logic [DW-1:0] p_pcn;
    logic [DW-1:0] p_sd;

    logic [15:0]   lfsr;

    exec_top #(.DATA_W(DW)) u_exec_top (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [DW-1:0] rand_bits(input int nbits);
        logic [DW-1:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val  = {val[DW-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [DW-1:0] ref_alu(input logic [3:0] fn, input logic [DW-1:0] a,
                                              input logic [DW-1:0] b);
        case (fn)
            exec_pkg::FN_ADD, exec_pkg::FN_STORE: return a + b;
            exec_pkg::FN_SUB:    return a - b;
            exec_pkg::FN_AND:    return a & b;
            exec_pkg::FN_OR:     return a | b;
            exec_pkg::FN_XOR:    return a ^ b;
            exec_pkg::FN_SHL:    return a << b[4:0];
            exec_pkg::FN_SHR:    return a >> b[4:0];
            exec_pkg::FN_SRA:    return $signed(a) >>> b[4:0];
            exec_pkg::FN_PASS_B: return b;
            default:             return '0;
        endcase
    endfunction

    function automatic logic cond_met(input logic [1:0] cond, input logic [1:0] fl);
        case (cond)
            exec_pkg::COND_EQ: return fl[0];
            exec_pkg::COND_NE: return !fl[0];
            exec_pkg::COND_LT: return fl[1];
            default:           return 1'b1;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_stages();
        check_val("exm_mem_wrt", exm_mem_wrt, p_mw);
        check_val("exm_taken", exm_taken, p_taken);
        if (p_valid[0]) begin
            check_val("exm_alu_out", exm_alu_out, p_data[0]);
            check_val("exm_pc_next", exm_pc_next, p_pcn);
            check_val("exm_store_data", exm_store_data, p_sd);
        end
        check_val("wb_valid", wb_valid, p_valid[1]);
        check_val("wb_reg_wrt_en", wb_reg_wrt_en, p_rw[1]);
        check_val("wb_fl_wrt", wb_fl_wrt, p_fw[1]);
        check_val("wb_lr_wrt", wb_lr_wrt, p_lw[1]);
        if (p_valid[1]) begin
            check_val("wb_dest", wb_dest, p_dest[1]);
            check_val("wb_data", wb_data, p_data[1]);
            check_val("wb_fl", wb_fl, p_fl[1]);
            check_val("wb_lr", wb_lr, p_lr[1]);
        end
    endtask

    // one clock, check both stages, then move the expectations down
    task automatic advance();
        @(posedge clk);
        #10;
        check_stages();
        // the entry that left MEM/WB at this edge is now architectural
        if (p_valid[2] && p_rw[2] && p_dest[2] != '0) begin
            arch_rf[p_dest[2]] = p_data[2];
        end
        if (p_valid[2] && p_fw[2]) begin
            arch_fl = p_fl[2];
        end
        if (p_valid[2] && p_lw[2]) begin
            arch_lr = p_lr[2];
        end
        for (int s = 2; s > 0; s--) begin
            p_valid[s] = p_valid[s-1];
            p_dest[s]  = p_dest[s-1];
            p_rw[s]    = p_rw[s-1];
            p_fw[s]    = p_fw[s-1];
            p_lw[s]    = p_lw[s-1];
            p_data[s]  = p_data[s-1];
            p_fl[s]    = p_fl[s-1];
            p_lr[s]    = p_lr[s-1];
        end
    endtask

    task automatic send(input logic [4:0] opw, input logic [7:0] ctl, input logic [RW-1:0] s1,
                        input logic [RW-1:0] s2, input logic [RW-1:0] d,
                        input logic [DW-1:0] immv);
        logic [DW-1:0] a;
        logic [DW-1:0] o2;
        logic [DW-1:0] res;
        logic [3:0]    fn;
        advance();
        a   = ctl[7] ? model_lr : model_rf[s1];  // fully forwarded operands
        o2  = model_rf[s2];
        fn  = opw[4] ? exec_pkg::FN_ERR : opw[3:0];
        res = ref_alu(fn, a, ctl[2] ? immv : o2);
        p_valid[0] = 1'b1;
        p_dest[0]  = d;
        p_rw[0]    = ctl[3];
        p_fw[0]    = ctl[4];
        p_lw[0]    = ctl[5];
        p_mw       = ctl[6];
        p_data[0]  = res;
        p_fl[0]    = {res[DW-1], res == '0};
        p_lr[0]    = next_pc + 4;
        p_sd       = (fn == exec_pkg::FN_STORE) ? a : o2;
        if (ctl[1]) begin
            p_pcn   = a;
            p_taken = 1'b1;
        end else if (ctl[0] && cond_met(opw[1:0], model_fl)) begin
            p_pcn   = next_pc + immv + 4;
            p_taken = 1'b1;
        end else begin
            p_pcn   = next_pc + 4;
            p_taken = 1'b0;
        end
        if (ctl[3] && d != '0) begin
            model_rf[d] = res;
        end
        if (ctl[4]) begin
            model_fl = p_fl[0];
        end
        if (ctl[5]) begin
            model_lr = p_lr[0];
        end
        issue_valid = 1'b1;
        op          = opw;
        branch      = ctl[0];
        jump        = ctl[1];
        alu_src     = ctl[2];
        reg_wrt_en  = ctl[3];
        fl_wrt      = ctl[4];
        lr_wrt      = ctl[5];
        mem_wrt     = ctl[6];
        src1_is_lr  = ctl[7];
        src1        = s1;
        src2        = s2;
        dest        = d;
        imm         = immv;
        pc          = next_pc;
        reg_1       = arch_rf[s1];  // stale while the writer is in flight
        reg_2       = arch_rf[s2];
        id_fl       = arch_fl;
        id_lr       = arch_lr;
        next_pc     = next_pc + 4;
    endtask

    task automatic bubble();
        advance();
        p_valid[0]  = 1'b0;
        p_rw[0]     = 1'b0;
        p_fw[0]     = 1'b0;
        p_lw[0]     = 1'b0;
        p_mw        = 1'b0;
        p_taken     = 1'b0;
        issue_valid = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        reg_wrt_en  = 1'b0;
        fl_wrt      = 1'b0;
        lr_wrt      = 1'b0;
        mem_wrt     = 1'b0;
    endtask

    task automatic drain();
        bubble();
        bubble();
    endtask

    task automatic init_state();
        lfsr   = 16'd57118;
        arst_n = 1'b0;
        {issue_valid, branch, jump, alu_src, reg_wrt_en, fl_wrt, lr_wrt, mem_wrt} = '0;
        src1_is_lr = 1'b0;
        op         = '0;
        {imm, pc, reg_1, reg_2, id_lr} = '0;
        {src1, src2, dest} = '0;
        id_fl      = '0;
        for (int r = 0; r < 32; r++) begin
            arch_rf[r]  = (r == 0) ? '0 : rand_bits(DW);
            model_rf[r] = arch_rf[r];
        end
        arch_fl  = '0;
        model_fl = '0;
        arch_lr  = rand_bits(DW);
        model_lr = arch_lr;
        next_pc  = DW'('h100);
        for (int s = 0; s < 3; s++) begin
            {p_valid[s], p_rw[s], p_fw[s], p_lw[s]} = '0;
        end
        p_mw    = 1'b0;
        p_taken = 1'b0;
    endtask

    task automatic test_reset();
        arst_n = 1'b0;
        repeat (5) begin
            @(posedge clk);
            #10;
            check_stages();  // valid bits and enables low
        end
        arst_n = 1'b1;
    endtask

    task automatic test_alu_funcs();
        for (int f = 0; f < 16; f++) begin
            if (f < 9 || f >= 14) begin
                send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 1, rand_bits(DW));
                send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 2, rand_bits(DW));
                send({1'b0, 4'(f)}, C_RW | C_FW, 1, 2, 20, '0);
                send({1'b0, 4'(f)}, C_RW | C_FW | C_IMM, 2, 1, 21, rand_bits(DW));
            end
        end
        send(5'b1_0000, C_RW | C_FW, 1, 2, 22, '0);  // invalid op, zero result
        drain();
    endtask

    task automatic test_forwarding();
        send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 3, rand_bits(DW));
        send({1'b0, exec_pkg::FN_ADD}, C_RW | C_FW, 3, 3, 4, '0);   // both from EX/MEM
        send({1'b0, exec_pkg::FN_SUB}, C_RW | C_FW, 4, 3, 5, '0);   // EX/MEM and MEM/WB
        send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 6, rand_bits(DW));
        send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 6, rand_bits(DW));
        send({1'b0, exec_pkg::FN_OR}, C_RW, 6, 0, 7, '0);           // younger r6 wins
        send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 8, rand_bits(DW));
        send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 9, rand_bits(DW));
        send({1'b0, exec_pkg::FN_XOR}, C_RW, 5, 8, 10, '0);         // r8 one instr back
        send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 0, rand_bits(DW));
        send({1'b0, exec_pkg::FN_ADD}, C_RW, 0, 0, 11, '0);         // r0 stays zero
        drain();
    endtask

    task automatic test_branches();
        logic [DW-1:0] val;
        int            gap;
        for (int c = 0; c < 4; c++) begin
            for (int v = 0; v < 3; v++) begin
                case (v)
                    0:       val = '0;
                    1:       val = rand_bits(DW) | {1'b1, {(DW-1){1'b0}}};
                    default: val = (rand_bits(DW) >> 1) | DW'(1);
                endcase
                gap = (v + c) % 3;  // flags from EX/MEM, MEM/WB or id_fl
                send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_FW | C_IMM, 0, 0, 12, val);
                repeat (gap) begin
                    send({1'b0, exec_pkg::FN_ADD}, C_RW | C_IMM, 1, 0, 13, rand_bits(8));
                end
                send({3'b000, 2'(c)}, C_BR, 0, 0, 0, rand_bits(12));
            end
        end
        drain();
    endtask

    task automatic test_jump_link();
        logic [DW-1:0] target;
        target = rand_bits(DW) & ~DW'(3);
        send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 14, target);
        send({1'b0, exec_pkg::FN_ADD}, C_JMP | C_LW, 14, 0, 0, '0);
        // link read from EX/MEM, then MEM/WB, then retired
        send({1'b0, exec_pkg::FN_ADD}, C_LR | C_RW | C_IMM, 0, 0, 15, '0);
        send({1'b0, exec_pkg::FN_ADD}, C_LR | C_RW | C_IMM, 0, 0, 16, DW'(8));
        send({1'b0, exec_pkg::FN_ADD}, C_LR | C_RW | C_IMM, 0, 0, 17, '0);
        drain();
    endtask

    task automatic test_stores();
        send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 18, rand_bits(DW));
        send({1'b0, exec_pkg::FN_ADD}, C_MW | C_IMM, 1, 18, 0, DW'(16));    // data is r18
        bubble();
        send({1'b0, exec_pkg::FN_PASS_B}, C_RW | C_IMM, 0, 0, 19, rand_bits(DW));
        send({1'b0, exec_pkg::FN_STORE}, C_MW | C_IMM, 19, 1, 0, DW'(32));  // data is r19
        drain();
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * 100);
        $display("Simulation failed");
        $fatal(1, "watchdog expired before the tests finished");
    end

    initial begin
        init_state();
        test_reset();
        test_alu_funcs();
        test_forwarding();
        test_branches();
        test_jump_link();
        test_stores();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- exec_top.f
design/exec_pkg.sv
design/forward_unit.sv
design/alu.sv
design/branch_unit.sv
design/execute.sv
design/pipe_regs.sv
design/exec_top.sv
bench/exec_tb.sv

//--- Bender.yml
package:
  name: exec_top

sources:
  - design/exec_pkg.sv
  - design/forward_unit.sv
  - design/alu.sv
  - design/branch_unit.sv
  - design/execute.sv
  - design/pipe_regs.sv
  - design/exec_top.sv
  - target: simulation
    files:
      - bench/exec_tb.sv
